// File: compile.f
logic/interpPkg.sv
logic/rateControl.sv
logic/cicInterpolate.sv
logic/outputScaler.sv
logic/interpTop.sv
test/interpChecker.sv
test/interpTb.sv

// File: logic/cicInterpolate.sv
`default_nettype none

module cicInterpolate
   import interpPkg::*;
#(
   parameter int inWidth  = interpPkg::inWidth,
   parameter int accWidth = interpPkg::accWidth
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      clkEn,
   input  logic      flush,
   input  inSample_t dIn,
   output acc_t      dOut
);

   // The comb output of a third-order difference can reach 8x the input,
   // so the taps carry 4 guard bits.
   localparam int tapWidth = inWidth + 4;

   logic signed [tapWidth-1:0] sample;
   logic signed [tapWidth-1:0] sampleX3;
   logic signed [tapWidth-1:0] sum3;
   logic signed [tapWidth-1:0] tap0;
   logic signed [tapWidth-1:0] tap1;
   logic signed [tapWidth-1:0] tap2;
   logic signed [tapWidth-1:0] tap3;
   logic signed [accWidth-1:0] acc0;
   logic signed [accWidth-1:0] acc1;
   logic signed [accWidth-1:0] acc2;

   // The comb is built as a FIR so the difference has a single register of delay.
   // (1 - z^-1)^3 = 1 - 3z^-1 + 3z^-2 - z^-3
   assign sample   = {{(tapWidth - inWidth){dIn[inWidth-1]}}, dIn};
   assign sampleX3 = sample + (sample <<< 1);
   assign sum3     = tap2 + sample;

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         tap0 <= '0;
         tap1 <= '0;
         tap2 <= '0;
         tap3 <= '0;
      end else if (clkEn) begin
         tap0 <= sample;
         tap1 <= sampleX3 - tap0;
         tap2 <= tap1 - sampleX3;
         tap3 <= sum3;
      end else begin
         // Zero stuffing between input samples.
         tap3 <= '0;
      end
   end

   // Three integrators at the high rate.
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         acc0 <= '0;
         acc1 <= '0;
         acc2 <= '0;
      end else begin
         acc0 <= acc0 + {{(accWidth - tapWidth){tap3[tapWidth-1]}}, tap3};
         acc1 <= acc1 + acc0;
         acc2 <= acc2 + acc1;
      end
   end

   assign dOut = acc2;

   // The controller must never feed a sample while the filter is being cleared.
   noStrobeDuringFlush: assert property (
      @(posedge clk) disable iff (reset)
      !(clkEn && flush)
   );

endmodule

`default_nettype wire

// File: logic/interpPkg.sv
`default_nettype none

package interpPkg;

   // Widths of the sample path.
   parameter int inWidth  = 18;
   parameter int outWidth = 16;

   // The integrators need the input width plus log2(R^3 / R) bits of growth.
   // At the largest ratio of 256 that is 16 extra bits.
   parameter int accWidth = 34;

   // Range of the interpolation ratio, given as its base-2 logarithm.
   parameter int minLog2Ratio = 1;
   parameter int maxLog2Ratio = 8;

   // Input samples from the low-rate source.
   typedef logic signed [17:0] inSample_t;

   // Output samples after gain removal and saturation.
   typedef logic signed [15:0] outSample_t;

   // Integrator state and raw CIC output.
   typedef logic signed [33:0] acc_t;

   // Base-2 logarithm of the interpolation ratio.
   typedef logic [3:0] log2Ratio_t;

   // States of the rate controller.
   // The filter is held clear in every state except run.
   typedef enum logic [1:0] {
      idle,
      flush,
      run
   } ctrlState_t;

endpackage

`default_nettype wire

// File: logic/interpTop.sv
`default_nettype none

module interpTop
   import interpPkg::*;
#(
   parameter int inWidth  = interpPkg::inWidth,
   parameter int outWidth = interpPkg::outWidth,
   parameter int accWidth = interpPkg::accWidth
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       enable,
   input  log2Ratio_t log2Ratio,
   input  inSample_t  dIn,
   output logic       sampleStrobe,
   output outSample_t dOut,
   output logic       outValid,
   output logic       overflow
);

   logic       flush;
   log2Ratio_t activeLog2Ratio;
   acc_t       cicOut;

   rateControl rateControl_i (
      .clk             (clk),
      .reset           (reset),
      .enable          (enable),
      .log2Ratio       (log2Ratio),
      .sampleStrobe    (sampleStrobe),
      .flush           (flush),
      .activeLog2Ratio (activeLog2Ratio),
      .outValid        (outValid)
   );

   // The input strobe doubles as the comb clock enable.
   cicInterpolate #(
      .inWidth  (inWidth),
      .accWidth (accWidth)
   ) cicInterpolate_i (
      .clk   (clk),
      .reset (reset),
      .clkEn (sampleStrobe),
      .flush (flush),
      .dIn   (dIn),
      .dOut  (cicOut)
   );

   outputScaler #(
      .accWidth (accWidth),
      .outWidth (outWidth)
   ) outputScaler_i (
      .clk             (clk),
      .reset           (reset),
      .flush           (flush),
      .activeLog2Ratio (activeLog2Ratio),
      .cicIn           (cicOut),
      .dOut            (dOut),
      .overflow        (overflow)
   );

endmodule

`default_nettype wire

// File: logic/outputScaler.sv
`default_nettype none

module outputScaler
   import interpPkg::*;
#(
   parameter int accWidth = interpPkg::accWidth,
   parameter int outWidth = interpPkg::outWidth
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       flush,
   input  log2Ratio_t activeLog2Ratio,
   input  acc_t       cicIn,
   output outSample_t dOut,
   output logic       overflow
);

   // One extra bit keeps the rounding add from wrapping at full scale.
   localparam int sumWidth = accWidth + 1;

   localparam logic signed [sumWidth-1:0] maxOut = sumWidth'((2 ** (outWidth - 1)) - 1);
   localparam logic signed [sumWidth-1:0] minOut = -maxOut - sumWidth'(1);

   logic [4:0]                shiftAmt;
   logic signed [sumWidth-1:0] roundBit;
   logic signed [sumWidth-1:0] rounded;
   logic signed [sumWidth-1:0] shifted;
   logic                      saturateHigh;
   logic                      saturateLow;
   outSample_t                nextOut;

   // The CIC gain is R^2, and the extra 2 bits narrow 18 to 16.
   assign shiftAmt = {activeLog2Ratio, 1'b0} + 5'd2;

   always_comb begin
      roundBit     = sumWidth'(1) << (shiftAmt - 5'd1);
      rounded      = {cicIn[accWidth-1], cicIn} + roundBit;
      shifted      = rounded >>> shiftAmt;
      saturateHigh = shifted > maxOut;
      saturateLow  = shifted < minOut;
      if (saturateHigh) begin
         nextOut = {1'b0, {(outWidth - 1){1'b1}}};
      end else if (saturateLow) begin
         nextOut = {1'b1, {(outWidth - 1){1'b0}}};
      end else begin
         nextOut = shifted[outWidth-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         dOut     <= '0;
         overflow <= 1'b0;
      end else begin
         dOut <= nextOut;
         // Sticky until the next flush.
         if (saturateHigh || saturateLow) begin
            overflow <= 1'b1;
         end
      end
   end

   // Beyond 18 bits of shift the accumulator would be too narrow for the ratio.
   shiftInRange: assert property (
      @(posedge clk) disable iff (reset)
      shiftAmt <= 5'd18
   );

endmodule

`default_nettype wire

// File: logic/rateControl.sv
`default_nettype none

module rateControl
   import interpPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       enable,
   input  log2Ratio_t log2Ratio,
   output logic       sampleStrobe,
   output logic       flush,
   output log2Ratio_t activeLog2Ratio,
   output logic       outValid
);

   // Cycles from a strobe until that sample reaches the registered output.
   localparam int pipeDelay = 5;

   ctrlState_t state;
   logic       flushCount;
   logic [7:0] phase;
   logic [7:0] phaseReload;
   logic [2:0] delayCount;
   logic       ratioLegal;
   logic       leaveRun;

   assign ratioLegal = (log2Ratio >= log2Ratio_t'(minLog2Ratio)) &&
                       (log2Ratio <= log2Ratio_t'(maxLog2Ratio));

   // Any change of enable or ratio while running restarts through idle.
   assign leaveRun = !enable || (log2Ratio != activeLog2Ratio);

   // The phase counter runs from 2^N - 1 down to zero between strobes.
   assign phaseReload = 8'((9'd1 << activeLog2Ratio) - 9'd1);

   always_ff @(posedge clk) begin
      if (reset) begin
         state           <= idle;
         flushCount      <= 1'b0;
         phase           <= '0;
         delayCount      <= '0;
         activeLog2Ratio <= log2Ratio_t'(minLog2Ratio);
      end else begin
         case (state)
            idle: begin
               flushCount <= 1'b0;
               // An illegal ratio keeps the channel parked in idle.
               if (enable && ratioLegal) begin
                  activeLog2Ratio <= log2Ratio;
                  state           <= interpPkg::flush;
               end
            end
            interpPkg::flush: begin
               flushCount <= 1'b1;
               phase      <= '0;
               delayCount <= '0;
               if (flushCount) begin
                  state <= run;
               end
            end
            run: begin
               if (leaveRun) begin
                  state <= idle;
               end else begin
                  if (phase == '0) begin
                     phase <= phaseReload;
                  end else begin
                     phase <= phase - 8'd1;
                  end
                  if (delayCount != 3'(pipeDelay)) begin
                     delayCount <= delayCount + 3'd1;
                  end
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // The phase is zero on entry to run, so the first strobe is immediate.
   assign sampleStrobe = (state == run) && (phase == '0);
   assign flush        = (state != run);
   assign outValid     = (state == run) && (delayCount == 3'(pipeDelay));

   // Run opens with a strobe after exactly two cycles in the flush state.
   strobeAfterFlush: assert property (
      @(posedge clk) disable iff (reset)
      $fell(flush) |-> sampleStrobe &&
                       ($past(state, 1) == interpPkg::flush) &&
                       ($past(state, 2) == interpPkg::flush) &&
                       ($past(state, 3) == idle)
   );

   // The scaler's shift range relies on the latched ratio staying legal.
   ratioInRange: assert property (
      @(posedge clk) disable iff (reset)
      (state == run) |-> (activeLog2Ratio >= log2Ratio_t'(minLog2Ratio)) &&
                         (activeLog2Ratio <= log2Ratio_t'(maxLog2Ratio))
   );

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Builds the interpolator testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module interpTb -f compile.f

# The simulation result is judged from its printed output.
output=$(./obj_dir/VinterpTb || true)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

// File: test/interpChecker.sv
`default_nettype none

module interpChecker
   import interpPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       enable,
   input  log2Ratio_t log2Ratio,
   input  inSample_t  dIn,
   input  logic       sampleStrobe,
   input  outSample_t dOut,
   input  logic       outValid,
   input  logic       overflow,
   input  logic       sampleNow,
   input  int         testNumber,
   input  outSample_t expOut,
   input  logic       expOverflow,
   output int         passCount,
   output int         failCount
);

   int         testErrors    = 0;
   int         passTotal     = 0;
   int         failTotal     = 0;
   int         gap           = 0;
   int         lowCycles     = 0;
   int         changeAge     = 0;
   logic       haveStrobe    = 1'b0;
   logic       resetHeld     = 1'b0;
   logic       enabledBefore = 1'b0;
   log2Ratio_t runRatio      = '0;

   assign passCount = passTotal;
   assign failCount = failTotal;

   task automatic flagValue(input string what, input int got, input int expected);
      $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
      testErrors = testErrors + 1;
   endtask

   task automatic checkQuiet(input logic withOutput);
      if (sampleStrobe !== 1'b0) begin
         flagValue("sampleStrobe", int'(sampleStrobe), 0);
      end
      if (outValid !== 1'b0) begin
         flagValue("outValid", int'(outValid), 0);
      end
      if (withOutput && dOut !== '0) begin
         flagValue("dOut", int'(dOut), 0);
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         if (resetHeld) begin
            checkQuiet(1'b1);
         end
         resetHeld     = 1'b1;
         enabledBefore = 1'b0;
         haveStrobe    = 1'b0;
         changeAge     = 0;
         lowCycles     = 0;
      end else begin
         resetHeld = 1'b0;
         // Idle is reached one edge after enable falls, and dOut clears one edge later.
         if (!enable) begin
            if (lowCycles > 0) begin
               checkQuiet(lowCycles > 1);
            end
            lowCycles = lowCycles + 1;
         end else begin
            lowCycles = 0;
         end
         // A new ratio while enabled must go through idle and flush.
         if (changeAge > 0) begin
            checkQuiet(changeAge > 1);
         end
         if (enabledBefore && enable && log2Ratio != runRatio) begin
            changeAge = 1;
         end else if (changeAge == 1) begin
            changeAge = 2;
         end else begin
            changeAge = 0;
         end
         if (!enable || log2Ratio != runRatio) begin
            haveStrobe = 1'b0;
            gap        = 0;
            runRatio   = log2Ratio;
         end else if (sampleStrobe) begin
            if (haveStrobe && gap + 1 != (1 << runRatio)) begin
               flagValue("strobe interval", gap + 1, 1 << runRatio);
            end
            haveStrobe = 1'b1;
            gap        = 0;
         end else begin
            gap = gap + 1;
         end
         enabledBefore = enable;
      end
      if (sampleNow) begin
         if (dOut !== expOut) begin
            flagValue("dOut", int'(dOut), int'(expOut));
         end
         if (overflow !== expOverflow) begin
            flagValue("overflow", int'(overflow), int'(expOverflow));
         end
         if (outValid !== 1'b1) begin
            flagValue("outValid", int'(outValid), 1);
         end
         if (testErrors == 0) begin
            $display("Test %0d, log2Ratio %0d, dIn %0d: passed", testNumber, log2Ratio, dIn);
            passTotal = passTotal + 1;
         end else begin
            $display("Test %0d, log2Ratio %0d, dIn %0d: failed with %0d errors",
                     testNumber, log2Ratio, dIn, testErrors);
            failTotal = failTotal + 1;
         end
         testErrors = 0;
      end
   end

endmodule

`default_nettype wire

// File: test/interpStimulus.txt
# log2Ratio keepEnable dIn expectedDOut expectedOverflow
# keepEnable 1 changes the ratio while enable stays high.
1 0 1000 250 0
3 0 -1000 -250 0
5 1 4002 1001 0
8 0 -131072 -32768 0
2 0 131071 32767 1
4 0 131069 32767 0
6 1 7 2 0
2 1 -7 -2 0
7 0 6 2 0
1 1 -6 -1 0
4 1 -131072 -32768 0
3 0 2 1 0
5 0 -131071 -32768 0
1 0 131068 32767 0
2 1 131070 32767 1
3 1 1 0 0

// File: test/interpTb.sv
`default_nettype none

module interpTb
   import interpPkg::*;
();

   localparam int resetCycles    = 4;
   localparam int idleCycles     = 3;
   localparam int strobesPerTest = 8;
   localparam int settleCycles   = 6;

   logic       clk;
   logic       reset;
   logic       enable;
   log2Ratio_t log2Ratio;
   inSample_t  dIn;
   logic       sampleStrobe;
   outSample_t dOut;
   logic       outValid;
   logic       overflow;
   logic       sampleNow;
   int         testNumber;
   outSample_t expOut;
   logic       expOverflow;
   int         passCount;
   int         failCount;
   int         limitCycles = 0;
   int         ratioList[$];
   int         keepList[$];
   int         inputList[$];
   int         expectList[$];
   int         overflowList[$];

   interpTop interpTop_i (
      .clk          (clk),
      .reset        (reset),
      .enable       (enable),
      .log2Ratio    (log2Ratio),
      .dIn          (dIn),
      .sampleStrobe (sampleStrobe),
      .dOut         (dOut),
      .outValid     (outValid),
      .overflow     (overflow)
   );

   interpChecker interpChecker_i (
      .clk          (clk),
      .reset        (reset),
      .enable       (enable),
      .log2Ratio    (log2Ratio),
      .dIn          (dIn),
      .sampleStrobe (sampleStrobe),
      .dOut         (dOut),
      .outValid     (outValid),
      .overflow     (overflow),
      .sampleNow    (sampleNow),
      .testNumber   (testNumber),
      .expOut       (expOut),
      .expOverflow  (expOverflow),
      .passCount    (passCount),
      .failCount    (failCount)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // Lines starting with # are column notes; blank lines are skipped.
   task automatic loadStimulus();
      int    fd;
      int    fields;
      int    ratio;
      int    keep;
      int    value;
      int    expected;
      int    ovf;
      string line;
      fd = $fopen("test/interpStimulus.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line   = "";
            fields = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
               fields = $sscanf(line, "%d %d %d %d %d", ratio, keep, value, expected, ovf);
               if (fields == 5) begin
                  ratioList.push_back(ratio);
                  keepList.push_back(keep);
                  inputList.push_back(value);
                  expectList.push_back(expected);
                  overflowList.push_back(ovf);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // A kept line changes the ratio while enable stays high.
   task automatic runTest(input int index);
      int strobes;
      if (index == 0 || keepList[index] == 0) begin
         enable <= 1'b0;
         repeat (idleCycles) @(posedge clk);
      end
      enable    <= 1'b1;
      log2Ratio <= log2Ratio_t'(ratioList[index]);
      dIn       <= inSample_t'(inputList[index]);
      strobes = 0;
      while (strobes < strobesPerTest) begin
         @(posedge clk);
         if (sampleStrobe) begin
            strobes = strobes + 1;
         end
      end
      repeat (settleCycles) @(posedge clk);
      testNumber  <= index + 1;
      expOut      <= outSample_t'(expectList[index]);
      expOverflow <= (overflowList[index] != 0);
      sampleNow   <= 1'b1;
      @(posedge clk);
      sampleNow <= 1'b0;
   endtask

   initial begin
      int total;
      reset       = 1'b1;
      enable      = 1'b0;
      log2Ratio   = log2Ratio_t'(1);
      dIn         = '0;
      sampleNow   = 1'b0;
      testNumber  = 0;
      expOut      = '0;
      expOverflow = 1'b0;
      loadStimulus();
      if (ratioList.size() == 0) begin
         $display("The stimulus file could not be read or holds no tests.");
         $display("SOME TESTS FAILED");
         $finish;
      end else begin
         total = 0;
         foreach (ratioList[i]) begin
            total = total + 8 * (1 << ratioList[i]) + 20;
         end
         limitCycles = 2 * total;
         repeat (resetCycles) @(posedge clk);
         reset <= 1'b0;
         foreach (ratioList[i]) begin
            runTest(i);
         end
         // Give the checker one edge to count the last test.
         @(posedge clk);
         $display("Tests passed: %0d, failed: %0d", passCount, failCount);
         if (failCount == 0 && passCount == ratioList.size()) begin
            $display("ALL TESTS PASSED");
         end else begin
            $display("SOME TESTS FAILED");
         end
         $finish;
      end
   end

   initial begin
      wait (limitCycles > 0);
      repeat (limitCycles) @(posedge clk);
      $display("The simulation timed out after %0d cycles.", limitCycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
